// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ptw_sv32
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/pte_checker.sv ====
`timescale 1ns/1ns

module pte_checker (
    input  logic [ptw_pkg::PTE_W-1:0] pte_i,
    input  logic                      is_instr_i,
    // only meaningful for data walks
    input  logic                      is_store_i,
    input  logic                      mxr_i,
    input  ptw_pkg::walk_lvl_e        lvl_i,
    output ptw_pkg::pte_verdict_e     verdict_o
);

    import ptw_pkg::*;

    logic pte_v;
    logic pte_r;
    logic pte_w;
    logic pte_x;
    logic pte_a;
    logic pte_d;
    logic invalid;
    logic is_leaf;
    logic perm_ok;
    logic misaligned;

    assign pte_v = pte_i[PTE_V];
    assign pte_r = pte_i[PTE_R];
    assign pte_w = pte_i[PTE_W_BIT];
    assign pte_x = pte_i[PTE_X];
    assign pte_a = pte_i[PTE_A];
    assign pte_d = pte_i[PTE_D];

    // not valid, or the reserved write-only encoding
    assign invalid = ~pte_v | (~pte_r & pte_w);

    // any of r or x makes it a leaf, otherwise it points one level down
    assign is_leaf = pte_r | pte_x;

    // ------------------------------------------------------------------------
    // leaf permissions
    // ------------------------------------------------------------------------

    // accessed bit is software managed, a clear one faults
    always_comb begin
        if (is_instr_i) begin
            perm_ok = pte_x & pte_a;
        end else begin
            // mxr lets loads read from execute-only pages
            perm_ok = pte_a & (pte_r | (pte_x & mxr_i));
            // stores also need write permission and a set dirty bit
            if (is_store_i && (!pte_w || !pte_d)) begin
                perm_ok = 1'b0;
            end
        end
    end

    // a superpage must have its low ppn field clear
    assign misaligned = (lvl_i == LVL1) && (pte_i[PTE_PPN_LSB +: VPN_W] != '0);

    always_comb begin
        if (invalid) begin
            verdict_o = PTE_FAULT;
        end else if (!is_leaf) begin
            // no third level in sv32
            verdict_o = (lvl_i == LVL1) ? PTE_POINTER : PTE_FAULT;
        end else if (perm_ok && !misaligned) begin
            verdict_o = PTE_LEAF_OK;
        end else begin
            verdict_o = PTE_FAULT;
        end
    end

endmodule

// ==== source/ptw_fsm.sv ====
`timescale 1ns/1ns

module ptw_fsm (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    // word read port into the page tables
    output logic                            mem_req_o,
    output logic [ptw_pkg::PLEN-1:0]        mem_addr_o,
    input  logic                            mem_gnt_i,
    input  logic                            mem_rvalid_i,
    input  logic [ptw_pkg::PTE_W-1:0]       mem_rdata_i,
    // access type and csr state for the permission checks
    input  logic                            lsu_is_store_i,
    input  logic                            mxr_i,
    // status
    output logic                            ptw_active_o,
    output logic                            walking_instr_o,
    output logic                            ptw_error_o,
    // tlb update
    output logic                            itlb_update_valid_o,
    output logic                            dtlb_update_valid_o,
    output logic [2*ptw_pkg::VPN_W-1:0]     update_vpn_o,
    output logic                            update_is_4m_o,
    output logic [ptw_pkg::ASID_W-1:0]      update_asid_o,
    output logic [ptw_pkg::PTE_W-1:0]       update_content_o,
    output logic [ptw_pkg::VLEN-1:0]        update_vaddr_o,
    ptw_walk_if.walker                      walk
);

    import ptw_pkg::*;

    walk_state_e       state_q;
    walk_state_e       state_d;
    walk_lvl_e         lvl_q;
    walk_lvl_e         lvl_d;
    logic              is_instr_q;
    logic              is_instr_d;
    // set once a global pointer was crossed
    logic              global_q;
    logic              global_d;
    logic [VLEN-1:0]   vaddr_q;
    logic [VLEN-1:0]   vaddr_d;
    logic [ASID_W-1:0] asid_q;
    logic [ASID_W-1:0] asid_d;
    // word address of the entry being fetched
    logic [PLEN-1:0]   pptr_q;
    logic [PLEN-1:0]   pptr_d;
    // memory response, one cycle late
    logic              rvalid_q;
    logic [PTE_W-1:0]  rdata_q;
    pte_verdict_e      verdict;
    logic              update_valid;

    pte_checker i_pte_checker (
        .pte_i      (rdata_q),
        .is_instr_i (is_instr_q),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .lvl_i      (lvl_q),
        .verdict_o  (verdict)
    );

    assign walk.idle       = (state_q == IDLE);
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;

    // request stays up with a stable address until granted
    assign mem_req_o  = (state_q == WAIT_GRANT);
    assign mem_addr_o = pptr_q;

    // ------------------------------------------------------------------------
    // tlb update fields
    // ------------------------------------------------------------------------

    assign itlb_update_valid_o = update_valid & is_instr_q;
    assign dtlb_update_valid_o = update_valid & ~is_instr_q;
    assign update_vpn_o        = vaddr_q[VLEN-1:PAGE_OFF_W];
    assign update_is_4m_o      = (lvl_q == LVL1);
    assign update_asid_o       = asid_q;
    assign update_vaddr_o      = vaddr_q;
    // global from the level 1 pointer carries into the leaf
    assign update_content_o    = rdata_q | (PTE_W'(global_q) << PTE_G);

    // ------------------------------------------------------------------------
    // walk control
    // ------------------------------------------------------------------------

    always_comb begin
        state_d      = state_q;
        lvl_d        = lvl_q;
        is_instr_d   = is_instr_q;
        global_d     = global_q;
        vaddr_d      = vaddr_q;
        asid_d       = asid_q;
        pptr_d       = pptr_q;
        update_valid = 1'b0;
        ptw_error_o  = 1'b0;

        case (state_q)
            IDLE: begin
                // every walk begins at the top level
                lvl_d      = LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                if (walk.start) begin
                    is_instr_d = walk.is_instr;
                    vaddr_d    = walk.vaddr;
                    asid_d     = walk.asid;
                    pptr_d     = walk.root_pptr;
                    state_d    = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    global_d = global_q | rdata_q[PTE_G];
                    case (verdict)
                        PTE_POINTER: begin
                            // pte.ppn * 4096 + vpn[0] * 4
                            lvl_d   = LVL2;
                            pptr_d  = {rdata_q[PTE_W-1:PTE_PPN_LSB],
                                       vaddr_q[PAGE_OFF_W +: VPN_W], 2'b00};
                            state_d = WAIT_GRANT;
                        end
                        PTE_LEAF_OK: begin
                            update_valid = 1'b1;
                            state_d      = IDLE;
                        end
                        default: begin
                            state_d = PROPAGATE_ERROR;
                        end
                    endcase
                end
            end
            // drain the read of a flushed walk
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end
            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // flush kills the walk, but a read already granted must still return
        if (flush_i) begin
            update_valid = 1'b0;
            ptw_error_o  = 1'b0;
            if ((state_q == PTE_LOOKUP && !rvalid_q) ||
                (state_q == WAIT_GRANT && mem_gnt_i)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rvalid_i;
        end
    end

    // walk payload
    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
        pptr_q  <= pptr_d;
        rdata_q <= mem_rdata_i;
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------

    // the memory sees one fixed address for each request
    a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i && !flush_i |=> mem_req_o && $stable(mem_addr_o));

    a_one_update : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_valid_o && dtlb_update_valid_o));

    // a walk ends in an update or an error, never both
    a_error_xor_update : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptw_error_o |-> !(itlb_update_valid_o || dtlb_update_valid_o));

endmodule

// ==== source/ptw_miss_select.sv ====
`timescale 1ns/1ns

module ptw_miss_select (
    // translation enables from the csr file
    input  logic                         enable_translation_i,
    input  logic                         en_ld_st_translation_i,
    // instruction tlb lookup
    input  logic                         itlb_access_i,
    input  logic                         itlb_hit_i,
    input  logic [ptw_pkg::VLEN-1:0]     itlb_vaddr_i,
    // data tlb lookup
    input  logic                         dtlb_access_i,
    input  logic                         dtlb_hit_i,
    input  logic [ptw_pkg::VLEN-1:0]     dtlb_vaddr_i,
    // address space and root table
    input  logic [ptw_pkg::ASID_W-1:0]   asid_i,
    input  logic [ptw_pkg::PPN_W-1:0]    satp_ppn_i,
    // performance counter pulses
    output logic                         itlb_miss_o,
    output logic                         dtlb_miss_o,
    ptw_walk_if.selector                 walk
);

    import ptw_pkg::*;

    // address of the miss being served
    logic [VLEN-1:0] sel_vaddr;

    // ------------------------------------------------------------------------
    // miss qualification
    // ------------------------------------------------------------------------

    // instruction miss wins unless a data access is present this cycle
    assign itlb_miss_o = walk.idle & enable_translation_i & itlb_access_i
                         & ~itlb_hit_i & ~dtlb_access_i;

    // data miss needs its own access, so it never collides with the above
    assign dtlb_miss_o = walk.idle & en_ld_st_translation_i & dtlb_access_i
                         & ~dtlb_hit_i;

    assign sel_vaddr = itlb_miss_o ? itlb_vaddr_i : dtlb_vaddr_i;

    // ------------------------------------------------------------------------
    // walk request
    // ------------------------------------------------------------------------

    assign walk.start    = itlb_miss_o | dtlb_miss_o;
    assign walk.is_instr = itlb_miss_o;
    assign walk.vaddr    = sel_vaddr;
    assign walk.asid     = asid_i;

    // satp.ppn * 4096 + vpn[1] * 4, entries are word sized
    assign walk.root_pptr = {satp_ppn_i, sel_vaddr[VLEN-1 -: VPN_W], 2'b00};

    // each miss counter sees at most one event per cycle
    always_comb begin
        assert final (!(itlb_miss_o && dtlb_miss_o))
            else $error("itlb and dtlb miss pulsed together");
    end

endmodule

// ==== source/ptw_pkg.sv ====
package ptw_pkg;

    // ------------------------------------------------------------------------
    // address and entry widths
    // ------------------------------------------------------------------------

    // sv32 virtual address
    localparam int VLEN       = 32;
    // physical address, a 22 bit ppn on top of the page offset
    localparam int PLEN       = 34;
    localparam int PPN_W      = 22;
    // one vpn field, a virtual address holds two of them
    localparam int VPN_W      = 10;
    localparam int PAGE_OFF_W = 12;
    localparam int ASID_W     = 9;
    // one pte is exactly one memory word
    localparam int PTE_W      = 32;

    // ------------------------------------------------------------------------
    // pte field positions
    // ------------------------------------------------------------------------

    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_G = 5;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;
    // bits 9:8 are rsw, ppn fills the rest of the word
    localparam int PTE_PPN_LSB = 10;

    // ------------------------------------------------------------------------
    // walker types
    // ------------------------------------------------------------------------

    // walk FSM states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

    // lvl1 maps a 4 MiB superpage, lvl2 a 4 KiB page
    typedef enum logic {
        LVL1,
        LVL2
    } walk_lvl_e;

    // what the checker made of the fetched entry
    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF_OK,
        PTE_FAULT
    } pte_verdict_e;

endpackage

// ==== source/ptw_sv32.sv ====
`timescale 1ns/1ns

module ptw_sv32 (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    // csr state
    input  logic                            enable_translation_i,
    input  logic                            en_ld_st_translation_i,
    input  logic                            lsu_is_store_i,
    input  logic                            mxr_i,
    input  logic [ptw_pkg::ASID_W-1:0]      asid_i,
    input  logic [ptw_pkg::PPN_W-1:0]       satp_ppn_i,
    // tlb lookups
    input  logic                            itlb_access_i,
    input  logic                            itlb_hit_i,
    input  logic [ptw_pkg::VLEN-1:0]        itlb_vaddr_i,
    input  logic                            dtlb_access_i,
    input  logic                            dtlb_hit_i,
    input  logic [ptw_pkg::VLEN-1:0]        dtlb_vaddr_i,
    // memory port
    output logic                            mem_req_o,
    output logic [ptw_pkg::PLEN-1:0]        mem_addr_o,
    input  logic                            mem_gnt_i,
    input  logic                            mem_rvalid_i,
    input  logic [ptw_pkg::PTE_W-1:0]       mem_rdata_i,
    // status
    output logic                            ptw_active_o,
    output logic                            walking_instr_o,
    output logic                            ptw_error_o,
    // tlb update
    output logic                            itlb_update_valid_o,
    output logic                            dtlb_update_valid_o,
    output logic [2*ptw_pkg::VPN_W-1:0]     update_vpn_o,
    output logic                            update_is_4m_o,
    output logic [ptw_pkg::ASID_W-1:0]      update_asid_o,
    output logic [ptw_pkg::PTE_W-1:0]       update_content_o,
    output logic [ptw_pkg::VLEN-1:0]        update_vaddr_o,
    // performance counters
    output logic                            itlb_miss_o,
    output logic                            dtlb_miss_o
);

    ptw_walk_if i_walk_if ();

    ptw_miss_select i_ptw_miss_select (
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .asid_i                 (asid_i),
        .satp_ppn_i             (satp_ppn_i),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o),
        .walk                   (i_walk_if.selector)
    );

    ptw_fsm i_ptw_fsm (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .mem_req_o           (mem_req_o),
        .mem_addr_o          (mem_addr_o),
        .mem_gnt_i           (mem_gnt_i),
        .mem_rvalid_i        (mem_rvalid_i),
        .mem_rdata_i         (mem_rdata_i),
        .lsu_is_store_i      (lsu_is_store_i),
        .mxr_i               (mxr_i),
        .ptw_active_o        (ptw_active_o),
        .walking_instr_o     (walking_instr_o),
        .ptw_error_o         (ptw_error_o),
        .itlb_update_valid_o (itlb_update_valid_o),
        .dtlb_update_valid_o (dtlb_update_valid_o),
        .update_vpn_o        (update_vpn_o),
        .update_is_4m_o      (update_is_4m_o),
        .update_asid_o       (update_asid_o),
        .update_content_o    (update_content_o),
        .update_vaddr_o      (update_vaddr_o),
        .walk                (i_walk_if.walker)
    );

endmodule

// ==== source/ptw_walk_if.sv ====
`timescale 1ns/1ns

interface ptw_walk_if;

    import ptw_pkg::*;

    // one cycle pulse, only while the walker is idle
    logic              start;
    // walk is for the instruction tlb
    logic              is_instr;
    logic [VLEN-1:0]   vaddr;
    logic [ASID_W-1:0] asid;
    // address of the first level entry
    logic [PLEN-1:0]   root_pptr;
    // walker can take a new request
    logic              idle;

    modport selector (
        output start,
        output is_instr,
        output vaddr,
        output asid,
        output root_pptr,
        input  idle
    );

    modport walker (
        input  start,
        input  is_instr,
        input  vaddr,
        input  asid,
        input  root_pptr,
        output idle
    );

endinterface

// ==== sources.f ====
source/ptw_pkg.sv
source/ptw_walk_if.sv
source/ptw_miss_select.sv
source/pte_checker.sv
source/ptw_fsm.sv
source/ptw_sv32.sv
verification/tb_ptw_sv32.sv

// ==== verification/tb_ptw_sv32.sv ====
`timescale 1ns/1ns

module tb_ptw_sv32;

    import ptw_pkg::*;

    localparam int NUM_WALKS   = 150;
    localparam int WALK_CYCLES = 60;
    localparam int VERD_PTR    = 0;
    localparam int VERD_LEAF   = 1;
    localparam int VERD_FAULT  = 2;
    localparam longint WATCHDOG_NS = longint'(NUM_WALKS) * 40 * 100;

    int seed = 32'hf6bd;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    logic enable_translation_i;
    logic en_ld_st_translation_i;
    logic lsu_is_store_i;
    logic mxr_i;
    logic [ASID_W-1:0] asid_i;
    logic [PPN_W-1:0] satp_ppn_i;
    logic itlb_access_i;
    logic itlb_hit_i;
    logic [VLEN-1:0] itlb_vaddr_i;
    logic dtlb_access_i;
    logic dtlb_hit_i;
    logic [VLEN-1:0] dtlb_vaddr_i;
    logic mem_req_o;
    logic [PLEN-1:0] mem_addr_o;
    logic mem_gnt_i;
    logic mem_rvalid_i;
    logic [PTE_W-1:0] mem_rdata_i;
    logic ptw_active_o;
    logic walking_instr_o;
    logic ptw_error_o;
    logic itlb_update_valid_o;
    logic dtlb_update_valid_o;
    logic [2*VPN_W-1:0] update_vpn_o;
    logic update_is_4m_o;
    logic [ASID_W-1:0] update_asid_o;
    logic [PTE_W-1:0] update_content_o;
    logic [VLEN-1:0] update_vaddr_o;
    logic itlb_miss_o;
    logic dtlb_miss_o;

    // sparse page table memory, word addressed by the full physical address
    logic [PTE_W-1:0] pt_mem [logic [PLEN-1:0]];
    logic [PLEN-1:0]  addr_log [$];
    int error_cnt;
    int outcome_cnt;
    int gnt_wait;
    int n_update;
    int n_fault;
    int n_flush;

    ptw_sv32 i_ptw_sv32 (.*);

    always #50 clk_i = ~clk_i;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // unwritten words still read back as something tied to their address
    function automatic logic [PTE_W-1:0] read_mem(input logic [PLEN-1:0] a);
        if (pt_mem.exists(a)) begin
            return pt_mem[a];
        end
        return a[31:0] ^ {30'h0, a[33:32]} ^ 32'h5a5a_0000;
    endfunction

    // mix of pointers and leaves with mostly sensible flags
    function automatic logic [PTE_W-1:0] make_pte(input bit top_lvl);
        logic [PTE_W-1:0] p;
        p = $random(seed);
        if (rand_below(10) < (top_lvl ? 4 : 1)) begin
            p[PTE_V]     = 1'b1;
            p[PTE_R]     = 1'b0;
            p[PTE_W_BIT] = 1'b0;
            p[PTE_X]     = 1'b0;
        end else begin
            p[PTE_V] = (rand_below(8) != 0);
            p[PTE_A] = (rand_below(6) != 0);
            p[PTE_D] = (rand_below(3) != 0);
            if (top_lvl && rand_below(4) != 0) begin
                p[PTE_PPN_LSB +: VPN_W] = '0;
            end
        end
        return p;
    endfunction

    // sv32 entry rules, written from the privileged spec
    function automatic int pte_verdict(input logic [PTE_W-1:0] p, input bit instr,
                                       input bit store, input bit mxr, input bit top_lvl);
        bit leaf_ok;
        if (!p[PTE_V] || (p[PTE_W_BIT] && !p[PTE_R])) begin
            return VERD_FAULT;
        end
        if (!p[PTE_R] && !p[PTE_X]) begin
            return top_lvl ? VERD_PTR : VERD_FAULT;
        end
        if (instr) begin
            leaf_ok = p[PTE_X] && p[PTE_A];
        end else if (store) begin
            leaf_ok = p[PTE_A] && p[PTE_W_BIT] && p[PTE_D];
        end else begin
            leaf_ok = p[PTE_A] && (p[PTE_R] || (mxr && p[PTE_X]));
        end
        if (top_lvl && p[PTE_PPN_LSB +: VPN_W] != '0) begin
            return VERD_FAULT;
        end
        return leaf_ok ? VERD_LEAF : VERD_FAULT;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
            error_cnt++;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("mem_req_o", 64'(0), 64'(mem_req_o));
        check_value("itlb_update_valid_o", 64'(0), 64'(itlb_update_valid_o));
        check_value("dtlb_update_valid_o", 64'(0), 64'(dtlb_update_valid_o));
        check_value("ptw_error_o", 64'(0), 64'(ptw_error_o));
        check_value("itlb_miss_o", 64'(0), 64'(itlb_miss_o));
        check_value("dtlb_miss_o", 64'(0), 64'(dtlb_miss_o));
        check_value("ptw_active_o", 64'(0), 64'(ptw_active_o));
    endtask

    // ------------------------------------------------------------------------
    // memory responder
    // ------------------------------------------------------------------------

    // decides at the falling edge, drives at the rising edge
    always begin
        logic [PLEN-1:0] req_addr;
        int rsp_dly;
        @(negedge clk_i);
        if (rst_ni && mem_req_o && !flush_i) begin
            if (gnt_wait < 0) begin
                gnt_wait = rand_below(4);
                addr_log.push_back(mem_addr_o);
            end
            if (gnt_wait == 0) begin
                req_addr = mem_addr_o;
                @(posedge clk_i);
                mem_gnt_i <= 1'b1;
                @(posedge clk_i);
                mem_gnt_i <= 1'b0;
                // read valid 1 to 4 cycles after the grant
                rsp_dly = 1 + rand_below(4);
                repeat (rsp_dly - 1) @(posedge clk_i);
                mem_rdata_i  <= read_mem(req_addr);
                mem_rvalid_i <= 1'b1;
                @(posedge clk_i);
                mem_rvalid_i <= 1'b0;
                gnt_wait = -1;
            end else begin
                gnt_wait = gnt_wait - 1;
            end
        end else begin
            gnt_wait = -1;
        end
    end

    // every update or error pulse
    always @(negedge clk_i) begin
        if (rst_ni && (itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o)) begin
            outcome_cnt = outcome_cnt + 1;
        end
    end

    // ------------------------------------------------------------------------
    // one walk
    // ------------------------------------------------------------------------

    // kind 0 fetch, 1 load, 2 store, 3 fetch and data access together
    task automatic run_walk(input int idx, input int kind, input bit do_flush);
        logic [VLEN-1:0]  vaddr;
        logic [PPN_W-1:0] satp;
        logic [ASID_W-1:0] asid;
        logic [PLEN-1:0]  root;
        logic [PLEN-1:0]  next;
        logic [PLEN-1:0]  exp_addr [$];
        logic [PTE_W-1:0] pte1;
        logic [PTE_W-1:0] pte2;
        logic [PTE_W-1:0] exp_content;
        bit is_instr;
        bit store;
        bit mxr;
        bit exp_ok;
        bit exp_4m;
        bit done;
        int v1;
        int start_cnt;
        int start_err;
        int waited;
        vaddr    = $random(seed);
        satp     = PPN_W'($random(seed));
        asid     = ASID_W'($random(seed));
        is_instr = (kind == 0);
        // fetch walks see a random store flag that must not matter
        store    = (kind == 2) || (kind != 1 && rand_below(2) == 1);
        mxr      = (rand_below(2) == 1);
        start_err = error_cnt;

        // reference walk over the same table
        root = {satp, vaddr[31:22], 2'b00};
        exp_addr.push_back(root);
        pte1 = make_pte(1'b1);
        pt_mem[root] = pte1;
        v1 = pte_verdict(pte1, is_instr, store, mxr, 1'b1);
        exp_ok      = (v1 == VERD_LEAF);
        exp_4m      = 1'b1;
        exp_content = pte1;
        if (v1 == VERD_PTR) begin
            next = {pte1[31:10], vaddr[21:12], 2'b00};
            if (next == root) begin
                pte1[31]     = ~pte1[31];
                pt_mem[root] = pte1;
                next         = {pte1[31:10], vaddr[21:12], 2'b00};
            end
            exp_addr.push_back(next);
            pte2 = make_pte(1'b0);
            pt_mem[next] = pte2;
            exp_ok      = (pte_verdict(pte2, is_instr, store, mxr, 1'b0) == VERD_LEAF);
            exp_4m      = 1'b0;
            exp_content = pte2;
            exp_content[PTE_G] = pte2[PTE_G] | pte1[PTE_G];
        end

        addr_log.delete();
        start_cnt = outcome_cnt;
        @(posedge clk_i);
        satp_ppn_i     <= satp;
        asid_i         <= asid;
        mxr_i          <= mxr;
        lsu_is_store_i <= store;
        itlb_access_i  <= (kind == 0 || kind == 3);
        itlb_vaddr_i   <= (kind == 0) ? vaddr : VLEN'($random(seed));
        dtlb_access_i  <= (kind != 0);
        dtlb_vaddr_i   <= vaddr;
        @(negedge clk_i);
        check_value("itlb_miss_o", 64'(is_instr), 64'(itlb_miss_o));
        check_value("dtlb_miss_o", 64'(!is_instr), 64'(dtlb_miss_o));
        @(posedge clk_i);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;

        if (do_flush) begin
            repeat (rand_below(4)) @(posedge clk_i);
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
            waited = 0;
            while (ptw_active_o && waited < WALK_CYCLES) begin
                @(negedge clk_i);
                waited++;
            end
            if (ptw_active_o) begin
                $display("walk %0d: walker stayed active after flush", idx);
                error_cnt++;
            end
            repeat (4) @(posedge clk_i);
            check_value("outcome count", 64'(start_cnt), 64'(outcome_cnt));
            n_flush++;
        end else begin
            done   = 1'b0;
            waited = 0;
            while (!done && waited < WALK_CYCLES) begin
                @(negedge clk_i);
                done = itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o;
                waited++;
            end
            if (!done) begin
                $display("walk %0d: no update and no error before the time limit", idx);
                error_cnt++;
            end else if (exp_ok) begin
                check_value("walking_instr_o", 64'(is_instr), 64'(walking_instr_o));
                check_value("itlb_update_valid_o", 64'(is_instr), 64'(itlb_update_valid_o));
                check_value("dtlb_update_valid_o", 64'(!is_instr), 64'(dtlb_update_valid_o));
                check_value("update_vpn_o", 64'(vaddr[31:12]), 64'(update_vpn_o));
                check_value("update_asid_o", 64'(asid), 64'(update_asid_o));
                check_value("update_is_4m_o", 64'(exp_4m), 64'(update_is_4m_o));
                check_value("update_content_o", 64'(exp_content), 64'(update_content_o));
                check_value("update_vaddr_o", 64'(vaddr), 64'(update_vaddr_o));
                n_update++;
            end else begin
                check_value("walking_instr_o", 64'(is_instr), 64'(walking_instr_o));
                check_value("ptw_error_o", 64'(1), 64'(ptw_error_o));
                n_fault++;
            end
            check_value("mem_addr count", 64'(exp_addr.size()), 64'(addr_log.size()));
            foreach (exp_addr[k]) begin
                if (k < addr_log.size()) begin
                    check_value("mem_addr_o", 64'(exp_addr[k]), 64'(addr_log[k]));
                end
            end
            @(posedge clk_i);
            check_value("outcome count", 64'(start_cnt + 1), 64'(outcome_cnt));
        end
        $display("walk %0d kind %0d flush %0d: %s", idx, kind, do_flush,
                 (error_cnt == start_err) ? "ok" : "mismatch");
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        clk_i = 1'b0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        enable_translation_i = 1'b1;
        en_ld_st_translation_i = 1'b1;
        lsu_is_store_i = 1'b0;
        mxr_i = 1'b0;
        asid_i = '0;
        satp_ppn_i = '0;
        itlb_access_i = 1'b0;
        itlb_hit_i = 1'b0;
        itlb_vaddr_i = '0;
        dtlb_access_i = 1'b0;
        dtlb_hit_i = 1'b0;
        dtlb_vaddr_i = '0;
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        error_cnt = 0;
        outcome_cnt = 0;
        gnt_wait = -1;
        n_update = 0;
        n_fault = 0;
        n_flush = 0;

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_idle_outputs();
        $display("reset: %s", (error_cnt == 0) ? "ok" : "mismatch");

        // a flushed walk is always followed by a plain one
        for (int i = 0; i < NUM_WALKS; i++) begin
            run_walk(i, rand_below(4), (i % 5) == 4);
        end

        $display("walks %0d updates %0d faults %0d flushed %0d errors %0d",
                 NUM_WALKS, n_update, n_fault, n_flush, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the walks did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

endmodule
